// File: hdl/fpu_pkg.sv
package fpu_pkg;

    ////////////////////////////////
    // single precision format
    ////////////////////////////////
    localparam int EXP_W   = 8;
    localparam int FRAC_W  = 23;
    localparam int WORD_W  = 1 + EXP_W + FRAC_W;   // sign, exponent, fraction
    localparam int MAN_W   = FRAC_W + 1;           // fraction plus hidden one

    ////////////////////////////////
    // extended mantissa
    ////////////////////////////////
    // bit 27 carry headroom, bit 26 hidden one, 25..3 fraction, 2..0 guard
    localparam int GUARD_W     = 3;
    localparam int EXT_W       = MAN_W + GUARD_W + 1;
    localparam int HIDDEN_BIT  = EXT_W - 2;
    localparam int SHIFT_W     = 5;
    localparam int ALIGN_LIMIT = 27;   // smaller mantissa is gone from here on

    // one cycle per stage, four stages
    localparam int PIPE_LAT = 4;

    typedef logic [EXP_W-1:0]   exp_t;
    typedef logic [EXT_W-1:0]   ext_t;
    typedef logic [SHIFT_W-1:0] shift_t;
    typedef logic [WORD_W-1:0]  word_t;

    typedef enum logic [0:0] {
        FPU_OP_ADD = 1'b0,   // a + b
        FPU_OP_SUB = 1'b1    // a - b
    } fpu_op_e;

endpackage

// File: hdl/fpu_align_stage.sv
`timescale 1ns/1ns

module fpu_align_stage (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_valid,
    input  fpu_pkg::fpu_op_e  i_op,
    input  fpu_pkg::word_t    i_a,
    input  fpu_pkg::word_t    i_b,
    output logic              o_valid,
    output fpu_pkg::fpu_op_e  o_op,
    output logic              o_sign_big,
    output logic              o_sign_small,
    output fpu_pkg::exp_t     o_exp_big,
    output fpu_pkg::ext_t     o_man_big,
    output fpu_pkg::ext_t     o_man_small
);

    logic                           sign_a, sign_b;
    fpu_pkg::exp_t                  exp_a, exp_b;
    logic [fpu_pkg::FRAC_W-1:0]     frac_a, frac_b;
    fpu_pkg::ext_t                  man_a, man_b;
    logic                           a_is_big;
    fpu_pkg::exp_t                  exp_big, exp_small, exp_diff;
    fpu_pkg::ext_t                  man_big, man_small, man_small_sh;

    //////////////////////////////
    // unpack
    //////////////////////////////
    assign sign_a = i_a[fpu_pkg::WORD_W-1];
    assign sign_b = i_b[fpu_pkg::WORD_W-1] ^ (i_op == fpu_pkg::FPU_OP_SUB);  // a - b is a + (-b)
    assign exp_a  = i_a[fpu_pkg::WORD_W-2 -: fpu_pkg::EXP_W];
    assign exp_b  = i_b[fpu_pkg::WORD_W-2 -: fpu_pkg::EXP_W];
    assign frac_a = i_a[fpu_pkg::FRAC_W-1:0];
    assign frac_b = i_b[fpu_pkg::FRAC_W-1:0];

    // headroom, hidden one, fraction, empty guard bits
    assign man_a = {1'b0, 1'b1, frac_a, {fpu_pkg::GUARD_W{1'b0}}};
    assign man_b = {1'b0, 1'b1, frac_b, {fpu_pkg::GUARD_W{1'b0}}};

    // exponent first, mantissa breaks the tie
    assign a_is_big = (exp_a > exp_b) || ((exp_a == exp_b) && (frac_a >= frac_b));

    assign exp_big   = a_is_big ? exp_a : exp_b;
    assign exp_small = a_is_big ? exp_b : exp_a;
    assign man_big   = a_is_big ? man_a : man_b;
    assign man_small = a_is_big ? man_b : man_a;
    assign exp_diff  = exp_big - exp_small;

    // bits shifted out are dropped, no sticky
    assign man_small_sh = (exp_diff >= fpu_pkg::ALIGN_LIMIT) ? '0 :
                          man_small >> exp_diff[fpu_pkg::SHIFT_W-1:0];

    //////////////////////////////
    // stage register
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_op         <= i_op;
            o_sign_big   <= a_is_big ? sign_a : sign_b;
            o_sign_small <= a_is_big ? sign_b : sign_a;
            o_exp_big    <= exp_big;
            o_man_big    <= man_big;
            o_man_small  <= man_small_sh;
        end
    end

    // ordering must hold after the shift, or the ALU subtract goes negative
    a_small_le_big: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid |-> (o_man_small <= o_man_big))
        else $error("align: small mantissa above big one");

endmodule

// File: hdl/fpu_mant_alu_stage.sv
`timescale 1ns/1ns

module fpu_mant_alu_stage (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_valid,
    input  fpu_pkg::fpu_op_e  i_op,
    input  logic              i_sign_big,
    input  logic              i_sign_small,
    input  fpu_pkg::exp_t     i_exp_big,
    input  fpu_pkg::ext_t     i_man_big,
    input  fpu_pkg::ext_t     i_man_small,
    output logic              o_valid,
    output logic              o_sign,
    output fpu_pkg::exp_t     o_exp,
    output fpu_pkg::ext_t     o_man
);

    fpu_pkg::fpu_op_e  eff_op;
    fpu_pkg::ext_t     man_res;

    // subtract flip is already in the small sign
    assign eff_op = (i_sign_big == i_sign_small) ? fpu_pkg::FPU_OP_ADD : fpu_pkg::FPU_OP_SUB;

    always_comb begin
        case (eff_op)
            fpu_pkg::FPU_OP_ADD: man_res = i_man_big + i_man_small;  // may set bit 27
            fpu_pkg::FPU_OP_SUB: man_res = i_man_big - i_man_small;  // never negative
            default:             man_res = '0;
        endcase
    end

    //////////////////////////////
    // stage register
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_sign <= i_sign_big;   // big operand decides the sign
            o_exp  <= i_exp_big;
            o_man  <= man_res;
        end
    end

    // an unknown sign would pick the wrong mantissa operation
    a_op_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid |-> !$isunknown({i_op, i_sign_big, i_sign_small}))
        else $error("alu: opcode or sign unknown on a valid item");

endmodule

// File: hdl/fpu_normalize_stage.sv
`timescale 1ns/1ns

module fpu_normalize_stage (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_valid,
    input  logic           i_sign,
    input  fpu_pkg::exp_t  i_exp,
    input  fpu_pkg::ext_t  i_man,
    output logic           o_valid,
    output logic           o_sign,
    output fpu_pkg::exp_t  o_exp,
    output fpu_pkg::ext_t  o_man
);

    fpu_pkg::shift_t  top_pos;     // leading one below the headroom bit
    fpu_pkg::shift_t  lshift;
    logic             man_zero;
    logic             sign_n;
    fpu_pkg::exp_t    exp_n;
    fpu_pkg::ext_t    man_n;

    //////////////////////////////
    // leading one detect
    //////////////////////////////
    always_comb begin
        top_pos = '0;
        for (int k = 0; k < fpu_pkg::EXT_W - 1; k++) begin
            if (i_man[k]) begin
                top_pos = fpu_pkg::shift_t'(k);   // last hit is the highest
            end
        end
    end

    assign man_zero = (i_man == '0);
    assign lshift   = fpu_pkg::shift_t'(fpu_pkg::HIDDEN_BIT) - top_pos;

    //////////////////////////////
    // shift and exponent adjust
    //////////////////////////////
    always_comb begin
        sign_n = i_sign;
        if (man_zero) begin
            sign_n = 1'b0;   // cancellation gives +0
            exp_n  = '0;
            man_n  = '0;
        end else if (i_man[fpu_pkg::EXT_W-1]) begin
            // carry out of the add, lowest guard bit is lost
            exp_n = i_exp + fpu_pkg::exp_t'(1);
            man_n = i_man >> 1;
        end else begin
            exp_n = i_exp - {{(fpu_pkg::EXP_W - fpu_pkg::SHIFT_W){1'b0}}, lshift};
            man_n = i_man << lshift;
        end
    end

    //////////////////////////////
    // stage register
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_sign <= sign_n;
            o_exp  <= exp_n;
            o_man  <= man_n;
        end
    end

    // rounding expects the hidden one in place
    a_norm_form: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_valid && (o_man != '0)) |->
            (o_man[fpu_pkg::HIDDEN_BIT] && !o_man[fpu_pkg::EXT_W-1]))
        else $error("normalize: mantissa not in 01.x form");

endmodule

// File: hdl/fpu_round_stage.sv
`timescale 1ns/1ns

module fpu_round_stage (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_valid,
    input  logic            i_sign,
    input  fpu_pkg::exp_t   i_exp,
    input  fpu_pkg::ext_t   i_man,
    output logic            o_valid,
    output fpu_pkg::word_t  o_result
);

    logic                         round_up;
    logic [fpu_pkg::MAN_W:0]      man_rnd;     // one extra bit for the carry
    logic                         rnd_carry;
    fpu_pkg::exp_t                exp_r;
    logic [fpu_pkg::FRAC_W-1:0]   frac_r;
    fpu_pkg::word_t               result_n;

    // guard >= 100b means round half up
    assign round_up = i_man[fpu_pkg::GUARD_W-1];

    assign man_rnd = {1'b0, i_man[fpu_pkg::HIDDEN_BIT -: fpu_pkg::MAN_W]}
                   + {{fpu_pkg::MAN_W{1'b0}}, round_up};
    assign rnd_carry = man_rnd[fpu_pkg::MAN_W];

    // all-ones mantissa rolled over, so 1.0 at the next exponent
    assign exp_r  = rnd_carry ? i_exp + fpu_pkg::exp_t'(1) : i_exp;
    assign frac_r = man_rnd[fpu_pkg::FRAC_W-1:0];   // a carry leaves these zero

    assign result_n = (i_man == '0) ? '0 : {i_sign, exp_r, frac_r};

    //////////////////////////////
    // output register
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid  <= 1'b0;
            o_result <= '0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_result <= result_n;
            end
        end
    end

    // the downstream side samples o_valid every cycle
    a_valid_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$isunknown(o_valid))
        else $error("round: o_valid unknown");

endmodule

// File: hdl/fpu_addsub_pipe.sv
`timescale 1ns/1ns

module fpu_addsub_pipe (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_valid,
    input  fpu_pkg::fpu_op_e  i_op,
    input  fpu_pkg::word_t    i_a,
    input  fpu_pkg::word_t    i_b,
    output logic              o_valid,
    output fpu_pkg::word_t    o_result
);

    //////////////////////////////
    // stage to stage wires
    //////////////////////////////
    logic              align_valid;
    fpu_pkg::fpu_op_e  align_op;
    logic              align_sign_big, align_sign_small;
    fpu_pkg::exp_t     align_exp_big;
    fpu_pkg::ext_t     align_man_big, align_man_small;

    logic              alu_valid, alu_sign;
    fpu_pkg::exp_t     alu_exp;
    fpu_pkg::ext_t     alu_man;

    logic              norm_valid, norm_sign;
    fpu_pkg::exp_t     norm_exp;
    fpu_pkg::ext_t     norm_man;

    fpu_align_stage i_fpu_align_stage (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_valid),
        .i_op         (i_op),
        .i_a          (i_a),
        .i_b          (i_b),
        .o_valid      (align_valid),
        .o_op         (align_op),
        .o_sign_big   (align_sign_big),
        .o_sign_small (align_sign_small),
        .o_exp_big    (align_exp_big),
        .o_man_big    (align_man_big),
        .o_man_small  (align_man_small)
    );

    fpu_mant_alu_stage i_fpu_mant_alu_stage (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (align_valid),
        .i_op         (align_op),
        .i_sign_big   (align_sign_big),
        .i_sign_small (align_sign_small),
        .i_exp_big    (align_exp_big),
        .i_man_big    (align_man_big),
        .i_man_small  (align_man_small),
        .o_valid      (alu_valid),
        .o_sign       (alu_sign),
        .o_exp        (alu_exp),
        .o_man        (alu_man)
    );

    fpu_normalize_stage i_fpu_normalize_stage (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (alu_valid),
        .i_sign       (alu_sign),
        .i_exp        (alu_exp),
        .i_man        (alu_man),
        .o_valid      (norm_valid),
        .o_sign       (norm_sign),
        .o_exp        (norm_exp),
        .o_man        (norm_man)
    );

    fpu_round_stage i_fpu_round_stage (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (norm_valid),
        .i_sign       (norm_sign),
        .i_exp        (norm_exp),
        .i_man        (norm_man),
        .o_valid      (o_valid),
        .o_result     (o_result)
    );

endmodule

// File: bench/fpu_model.svh
`ifndef FPU_MODEL_SVH
`define FPU_MODEL_SVH

// expected results in issue order, with the test name for each
logic [31:0] exp_q[$];
string       name_q[$];

//////////////////////////////
// bit level add/sub model
//////////////////////////////
// integer arithmetic on mantissas scaled by 8, so the low three bits are guard bits
function automatic logic [31:0] model_addsub(input fpu_pkg::fpu_op_e op,
                                              input logic [31:0] a,
                                              input logic [31:0] b);
    logic        s_x, s_y, s_t;
    int          e_x, e_y, e_t;
    int          m_x, m_y, m_t;
    int          diff;
    int          m_r, e_r;
    int          frac, guard;
    logic [7:0]  e_out;
    logic [22:0] f_out;

    s_x = a[31];
    s_y = b[31] ^ (op == fpu_pkg::FPU_OP_SUB);   // subtract adds the negated b
    e_x = int'(a[30:23]);
    e_y = int'(b[30:23]);
    m_x = int'({1'b1, a[22:0]}) * 8;
    m_y = int'({1'b1, b[22:0]}) * 8;

    // x holds the larger magnitude, a wins a tie
    if ((e_y > e_x) || ((e_y == e_x) && (m_y > m_x))) begin
        s_t = s_x;
        e_t = e_x;
        m_t = m_x;
        s_x = s_y;
        e_x = e_y;
        m_x = m_y;
        s_y = s_t;
        e_y = e_t;
        m_y = m_t;
    end

    // truncating alignment
    diff = e_x - e_y;
    if (diff >= 27) begin
        m_y = 0;
    end else begin
        m_y = m_y >> diff;
    end

    if (s_x == s_y) begin
        m_r = m_x + m_y;
    end else begin
        m_r = m_x - m_y;
    end
    e_r = e_x;

    if (m_r == 0) begin
        return 32'h0000_0000;   // exact cancellation is +0
    end

    // normalize to 1.x with the hidden one at weight 2^26
    if (m_r >= (1 << 27)) begin
        m_r = m_r / 2;
        e_r = e_r + 1;
    end
    while (m_r < (1 << 26)) begin
        m_r = m_r * 2;
        e_r = e_r - 1;
    end

    // round half up
    frac  = m_r / 8;
    guard = m_r % 8;
    if (guard >= 4) begin
        frac = frac + 1;
    end
    if (frac == (1 << 24)) begin
        frac = 1 << 23;
        e_r  = e_r + 1;
    end

    e_out = e_r[7:0];
    f_out = frac[22:0];
    return {s_x, e_out, f_out};
endfunction

`endif

// File: bench/tb_fpu_addsub_pipe.sv
`timescale 1ns/1ns

module tb_fpu_addsub_pipe;

    localparam int RST_CYCLES     = 10;
    localparam int N_DIRECTED     = 9;
    localparam int N_RANDOM       = 400;
    localparam int TIMEOUT_CYCLES =
        2 * (N_DIRECTED + N_RANDOM + fpu_pkg::PIPE_LAT + RST_CYCLES);

    logic              i_clk;
    logic              i_rst_n;
    logic              i_valid;
    fpu_pkg::fpu_op_e  i_op;
    logic [31:0]       i_a;
    logic [31:0]       i_b;
    logic              o_valid;
    logic [31:0]       o_result;

    integer seed = 90;
    int     cycle = 0;
    int     value_errs = 0;
    int     other_errs = 0;
    int     first_in = -1;    // edge that drove the first input
    int     first_out = -1;

    `include "fpu_model.svh"

    fpu_addsub_pipe i_fpu_addsub_pipe (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_valid),
        .i_op     (i_op),
        .i_a      (i_a),
        .i_b      (i_b),
        .o_valid  (o_valid),
        .o_result (o_result)
    );

    initial i_clk = 1'b0;
    always #50 i_clk = ~i_clk;

    always @(posedge i_clk) cycle <= cycle + 1;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            value_errs++;
        end
    endtask

    // exponent kept in 40..200, so no special values come out
    function automatic logic [31:0] random_operand();
        logic [31:0] r;
        logic [7:0]  e;
        r = $random(seed);
        e = 8'(40 + ($unsigned($random(seed)) % 161));
        return {r[31], e, r[22:0]};
    endfunction

    task automatic send_item(input string name, input fpu_pkg::fpu_op_e op,
                             input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] expected);
        @(posedge i_clk);
        i_valid <= 1'b1;
        i_op    <= op;
        i_a     <= a;
        i_b     <= b;
        exp_q.push_back(expected);
        name_q.push_back(name);
    endtask

    //////////////////////////////
    // output monitor, negedge
    //////////////////////////////
    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            if (o_valid !== 1'b0) begin
                $display("o_valid was not low during reset at cycle %0d", cycle);
                other_errs++;
            end
        end else begin
            if (i_valid && (first_in < 0)) first_in = cycle;
            if ($isunknown(o_valid)) begin
                $display("o_valid is unknown at cycle %0d", cycle);
                other_errs++;
            end else if (o_valid) begin
                if (first_out < 0) first_out = cycle;
                if (exp_q.size() == 0) begin
                    $display("a result came out with no input waiting for it");
                    other_errs++;
                end else begin
                    check_value(name_q.pop_front(), exp_q.pop_front(), o_result);
                end
            end
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial begin
        logic [31:0]       a, b;
        fpu_pkg::fpu_op_e  op;
        i_rst_n = 1'b0;
        i_valid = 1'b0;
        i_op    = fpu_pkg::FPU_OP_ADD;
        i_a     = '0;
        i_b     = '0;
        repeat (RST_CYCLES) @(posedge i_clk);
        i_rst_n <= 1'b1;

        send_item("cancel_sub", fpu_pkg::FPU_OP_SUB, 32'h40490FDB, 32'h40490FDB, 32'h00000000);
        send_item("cancel_add", fpu_pkg::FPU_OP_ADD, 32'hC1200000, 32'h41200000, 32'h00000000);
        send_item("align_27", fpu_pkg::FPU_OP_ADD, 32'h41000000, 32'h33800000, 32'h41000000);
        send_item("align_47", fpu_pkg::FPU_OP_ADD, 32'h4B000001, 32'h33800000, 32'h4B000001);
        send_item("align_sub", fpu_pkg::FPU_OP_SUB, 32'h33800000, 32'h4B000001, 32'hCB000001);
        send_item("carry_1p5", fpu_pkg::FPU_OP_ADD, 32'h3FC00000, 32'h3FC00000, 32'h40400000);
        send_item("carry_5_7", fpu_pkg::FPU_OP_ADD, 32'h40A00000, 32'h40E00000, 32'h41400000);
        send_item("round_pos", fpu_pkg::FPU_OP_ADD, 32'h4B7FFFFF, 32'h3F000000, 32'h4B800000);
        send_item("round_neg", fpu_pkg::FPU_OP_SUB, 32'hCB7FFFFF, 32'h3F000000, 32'hCB800000);

        for (int n = 0; n < N_RANDOM; n++) begin
            a  = random_operand();
            b  = random_operand();
            op = $random(seed) & 1 ? fpu_pkg::FPU_OP_SUB : fpu_pkg::FPU_OP_ADD;
            send_item($sformatf("random_%0d", n), op, a, b, model_addsub(op, a, b));
        end
        @(posedge i_clk);
        i_valid <= 1'b0;

        while (exp_q.size() != 0) @(posedge i_clk);
        repeat (2) @(posedge i_clk);   // any stray result shows up here
        check_value("first_latency", fpu_pkg::PIPE_LAT, first_out - first_in);

        $display("summary: %0d value errors, %0d other errors", value_errs, other_errs);
        if ((value_errs + other_errs) == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, %0d results missing, %0d value errors, %0d other errors",
                 cycle, exp_q.size(), value_errs, other_errs);
        $display("tests failed");
        $finish;
    end

endmodule

// File: sources.f
hdl/fpu_pkg.sv
hdl/fpu_align_stage.sv
hdl/fpu_mant_alu_stage.sv
hdl/fpu_normalize_stage.sv
hdl/fpu_round_stage.sv
hdl/fpu_addsub_pipe.sv
+incdir+bench
bench/tb_fpu_addsub_pipe.sv
